//--- project.f
+incdir+include
verilog/lc3b_isa_pkg.sv
verilog/lc3b_ctrl_pkg.sv
verilog/lc3b_forward_if.sv
verilog/lc3b_control_rom.sv
verilog/regfile.sv
verilog/forwarding_unit.sv
verilog/hazard_detection.sv
verilog/cpu_datapath.sv
verilog/lc3b_cpu.sv
bench/lc3b_cpu_properties.sv
bench/lc3b_cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP       ?= lc3b_cpu_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/lc3b_cpu_tb.sv
`include "lc3b_params.svh"

module lc3b_cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import lc3b_isa_pkg::*;

    localparam int          prog_words = 48;
    localparam logic [15:0] prog_end   = 16'(prog_words * 2);
    localparam int          wait_limit = 6000;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [15:0] imem_address;
    logic        imem_read;
    logic        imem_resp;
    logic [15:0] imem_rdata;
    logic [15:0] dmem_address;
    logic [15:0] dmem_wdata;
    logic        dmem_read;
    logic        dmem_write;
    logic        dmem_resp;
    logic [15:0] dmem_rdata;

    int          seed = 32'hc281;
    logic [15:0] prog [prog_words];
    logic [15:0] dmem [256];
    logic [15:0] exp_addr[$];
    logic [15:0] exp_data[$];
    logic [15:0] first_access_addr;
    logic        first_is_read;

    // memory model state
    logic        imem_busy = 1'b0;
    logic        dmem_busy = 1'b0;
    int          imem_wait = 0;
    int          dmem_wait = 0;
    int          store_idx = 0;
    logic        access_seen = 1'b0;
    logic        fetch_past_end = 1'b0;

    lc3b_cpu i_lc3b_cpu (
        .clk            (clk),
        .i_arst_n       (arst_n),
        .o_imem_address (imem_address),
        .o_imem_read    (imem_read),
        .i_imem_resp    (imem_resp),
        .i_imem_rdata   (imem_rdata),
        .o_dmem_address (dmem_address),
        .o_dmem_wdata   (dmem_wdata),
        .o_dmem_read    (dmem_read),
        .o_dmem_write   (dmem_write),
        .i_dmem_resp    (dmem_resp),
        .i_dmem_rdata   (dmem_rdata)
    );

    always #4 clk = ~clk;

    task automatic fail_with(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        if (expected !== actual) begin
            fail_with($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic int rnd_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    // words past the program read as zero, a BR that is never taken
    function automatic logic [15:0] fetch_word(input logic [15:0] addr);
        if (addr < prog_end) begin
            return prog[addr[6:1]];
        end
        return 16'h0000;
    endfunction

    task automatic build_program();
        int         kind;
        logic [2:0] dr;
        logic [2:0] sr1;
        logic [2:0] sr2;
        logic [4:0] imm5;
        logic [5:0] off6;
        logic       imm;
        // load, dependent add, store of the sum
        prog[0] = {op_ldr, 3'd1, 3'd0, 6'd5};
        prog[1] = {op_add, 3'd2, 3'd1, 1'b1, 5'd3};
        prog[2] = {op_str, 3'd2, 3'd0, 6'd6};
        for (int i = 3; i < prog_words; i++) begin
            kind = rnd_below(8);
            dr   = 3'(rnd_below(8));
            sr1  = 3'(rnd_below(8));
            sr2  = 3'(rnd_below(8));
            imm5 = 5'(rnd_below(32));
            off6 = 6'(rnd_below(64));
            imm  = 1'(rnd_below(2));
            case (kind)
                0, 1: prog[i] = imm ? {op_add, dr, sr1, 1'b1, imm5}
                                    : {op_add, dr, sr1, 3'b000, sr2};
                2: prog[i] = imm ? {op_and, dr, sr1, 1'b1, imm5}
                                 : {op_and, dr, sr1, 3'b000, sr2};
                3: prog[i] = {op_not, dr, sr1, 6'h3f};
                4: prog[i] = {op_ldr, dr, sr1, off6};
                5, 6: prog[i] = {op_str, dr, sr1, off6};
                // forward only, 0 to 4 words past the next instruction
                default: prog[i] = {op_br, dr, 9'(rnd_below(5))};
            endcase
        end
    endtask

    task automatic fill_data_memory();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 16'($random(seed));
        end
    endtask

    // sequential execution of the program, collects the stores in order
    task automatic run_model();
        logic [15:0] regs [8];
        logic [15:0] mem [256];
        logic [15:0] pc;
        logic [15:0] ir;
        logic [15:0] addr;
        logic [15:0] b;
        logic [15:0] value;
        logic [2:0]  cc;
        logic        writes;
        logic        have_first;
        int          steps;
        for (int i = 0; i < 8; i++) begin
            regs[i] = 16'h0000;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = dmem[i];
        end
        pc         = `LC3B_RESET_PC;
        cc         = 3'b010;
        have_first = 1'b0;
        steps      = 0;
        while (pc < prog_end && steps < 4 * prog_words) begin
            ir     = prog[pc[6:1]];
            pc     = pc + 16'd2;
            steps++;
            writes = 1'b1;
            value  = 16'h0000;
            addr   = regs[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
            b      = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]];
            if ((ir[15:12] == op_ldr || ir[15:12] == op_str) && !have_first) begin
                have_first        = 1'b1;
                first_access_addr = addr;
                first_is_read     = (ir[15:12] == op_ldr);
            end
            case (ir[15:12])
                op_add: value = regs[ir[8:6]] + b;
                op_and: value = regs[ir[8:6]] & b;
                op_not: value = ~regs[ir[8:6]];
                op_ldr: value = mem[addr[8:1]];
                op_str: begin
                    writes          = 1'b0;
                    mem[addr[8:1]] = regs[ir[11:9]];
                    exp_addr.push_back(addr);
                    exp_data.push_back(regs[ir[11:9]]);
                end
                default: begin
                    writes = 1'b0;
                    if ((ir[11:9] & cc) != 3'b000) begin
                        pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
                    end
                end
            endcase
            if (writes) begin
                regs[ir[11:9]] = value;
                cc = value[15] ? 3'b100 : (value == 16'h0000) ? 3'b010 : 3'b001;
            end
        end
    endtask

    task automatic record_store();
        string name;
        if (store_idx >= exp_addr.size()) begin
            fail_with($sformatf("store to %h beyond the end of the expected store list",
                                dmem_address));
        end
        name = (store_idx == 0) ? "load-use store" : $sformatf("store %0d", store_idx);
        check({name, " address"}, exp_addr[store_idx], dmem_address);
        check({name, " data"}, exp_data[store_idx], dmem_wdata);
        dmem[dmem_address[8:1]] = dmem_wdata;
        store_idx++;
    endtask

    // memories answer 0 to 3 cycles after the strobe is seen
    always @(negedge clk) begin
        imem_resp = 1'b0;
        if (imem_read) begin
            if (!imem_busy) begin
                imem_busy = 1'b1;
                imem_wait = rnd_below(4);
            end
            if (imem_wait == 0) begin
                imem_busy  = 1'b0;
                imem_resp  = 1'b1;
                imem_rdata = fetch_word(imem_address);
                if (imem_address >= prog_end + 16'd16) begin
                    fetch_past_end = 1'b1;
                end
            end else begin
                imem_wait--;
            end
        end
        dmem_resp = 1'b0;
        if (dmem_read || dmem_write) begin
            if (!access_seen) begin
                access_seen = 1'b1;
                check("first data access is a read", 16'(first_is_read), 16'(dmem_read));
                check("first data access address", first_access_addr, dmem_address);
            end
            if (!dmem_busy) begin
                dmem_busy = 1'b1;
                dmem_wait = rnd_below(4);
            end
            if (dmem_wait == 0) begin
                dmem_busy = 1'b0;
                dmem_resp = 1'b1;
                if (dmem_write) begin
                    record_store();
                end else begin
                    dmem_rdata = dmem[dmem_address[8:1]];
                end
            end else begin
                dmem_wait--;
            end
        end
    end

    initial begin
        int cycles;
        arst_n     = 1'b0;
        imem_resp  = 1'b0;
        imem_rdata = 16'h0000;
        dmem_resp  = 1'b0;
        dmem_rdata = 16'h0000;
        build_program();
        fill_data_memory();
        run_model();

        repeat (10) @(negedge clk);
        arst_n = 1'b1;

        // fetch strobe rises in the first cycle after release, at the reset PC
        check("fetch strobe low in reset", 16'd0, 16'(imem_read));
        @(negedge clk);
        check("fetch strobe after reset release", 16'd1, 16'(imem_read));
        check("first fetch address", `LC3B_RESET_PC, imem_address);

        cycles = 0;
        while (store_idx < exp_addr.size()) begin
            @(posedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                fail_with($sformatf("timeout with %0d of %0d stores seen",
                                    store_idx, exp_addr.size()));
            end
        end

        // program drained once fetch is well past its last word
        cycles = 0;
        while (!fetch_past_end) begin
            @(posedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                fail_with("timeout waiting for fetch to pass the program end");
            end
        end
        repeat (20) @(posedge clk);

        if (i_lc3b_cpu.i_lc3b_cpu_properties.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            fail_with("bound assertions on the memory ports failed");
        end
    end
endmodule

//--- bench/lc3b_cpu_properties.sv
module lc3b_cpu_properties (
    input logic                   clk,
    input logic                   i_arst_n,
    input lc3b_isa_pkg::lc3b_word i_imem_address,
    input logic                   i_imem_read,
    input logic                   i_imem_resp,
    input lc3b_isa_pkg::lc3b_word i_dmem_address,
    input lc3b_isa_pkg::lc3b_word i_dmem_wdata,
    input logic                   i_dmem_read,
    input logic                   i_dmem_write,
    input logic                   i_dmem_resp
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    data_strobes_exclusive: assert property (@(posedge clk) !(i_dmem_read && i_dmem_write))
        else begin
            $error("data read and write strobes high together");
            fail_count++;
        end

    // fetch request held with the same address until answered
    imem_request_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_imem_read && !i_imem_resp |=> i_imem_read && $stable(i_imem_address))
        else begin
            $error("instruction fetch dropped or moved before its response");
            fail_count++;
        end

    dmem_request_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        (i_dmem_read || i_dmem_write) && !i_dmem_resp |=>
            $stable(i_dmem_read) && $stable(i_dmem_write) &&
            $stable(i_dmem_address) && $stable(i_dmem_wdata))
        else begin
            $error("data request changed before its response");
            fail_count++;
        end

    no_data_access_in_reset: assert property (@(posedge clk)
        !i_arst_n |-> !i_dmem_read && !i_dmem_write)
        else begin
            $error("data strobe high during reset");
            fail_count++;
        end
endmodule

bind lc3b_cpu lc3b_cpu_properties i_lc3b_cpu_properties (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_imem_address (o_imem_address),
    .i_imem_read    (o_imem_read),
    .i_imem_resp    (i_imem_resp),
    .i_dmem_address (o_dmem_address),
    .i_dmem_wdata   (o_dmem_wdata),
    .i_dmem_read    (o_dmem_read),
    .i_dmem_write   (o_dmem_write),
    .i_dmem_resp    (i_dmem_resp)
);

//--- verilog/lc3b_cpu.sv
module lc3b_cpu (
    input  logic                   clk,
    input  logic                   i_arst_n,
    // instruction memory
    output lc3b_isa_pkg::lc3b_word o_imem_address,
    output logic                   o_imem_read,
    input  logic                   i_imem_resp,
    input  lc3b_isa_pkg::lc3b_word i_imem_rdata,
    // data memory
    output lc3b_isa_pkg::lc3b_word o_dmem_address,
    output lc3b_isa_pkg::lc3b_word o_dmem_wdata,
    output logic                   o_dmem_read,
    output logic                   o_dmem_write,
    input  logic                   i_dmem_resp,
    input  lc3b_isa_pkg::lc3b_word i_dmem_rdata
);
    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;

    lc3b_control_word cw;
    lc3b_opcode       opcode;
    logic             ir_5;

    // decode of the instruction held in the IF/ID register
    lc3b_control_rom i_control_rom (
        .i_opcode (opcode),
        .i_ir_5   (ir_5),
        .o_cw     (cw)
    );

    cpu_datapath i_datapath (
        .clk,
        .i_arst_n,
        .i_cw           (cw),
        .o_opcode       (opcode),
        .o_ir_5         (ir_5),
        .o_imem_address (o_imem_address),
        .o_imem_read    (o_imem_read),
        .i_imem_resp    (i_imem_resp),
        .i_imem_rdata   (i_imem_rdata),
        .o_dmem_address (o_dmem_address),
        .o_dmem_wdata   (o_dmem_wdata),
        .o_dmem_read    (o_dmem_read),
        .o_dmem_write   (o_dmem_write),
        .i_dmem_resp    (i_dmem_resp),
        .i_dmem_rdata   (i_dmem_rdata)
    );
endmodule

//--- verilog/cpu_datapath.sv
`include "lc3b_params.svh"

module cpu_datapath (
    input  logic                            clk,
    input  logic                            i_arst_n,
    input  lc3b_ctrl_pkg::lc3b_control_word i_cw,
    output lc3b_isa_pkg::lc3b_opcode        o_opcode,
    output logic                            o_ir_5,
    output lc3b_isa_pkg::lc3b_word          o_imem_address,
    output logic                            o_imem_read,
    input  logic                            i_imem_resp,
    input  lc3b_isa_pkg::lc3b_word          i_imem_rdata,
    output lc3b_isa_pkg::lc3b_word          o_dmem_address,
    output lc3b_isa_pkg::lc3b_word          o_dmem_wdata,
    output logic                            o_dmem_read,
    output logic                            o_dmem_write,
    input  logic                            i_dmem_resp,
    input  lc3b_isa_pkg::lc3b_word          i_dmem_rdata
);
    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;

    // fetch and decode
    lc3b_word         pc;
    lc3b_word         pc_plus2;
    logic             fetch_en;
    lc3b_word         ir_id;
    lc3b_word         pc2_id;
    lc3b_word         reg_a_id;
    lc3b_word         reg_b_id;
    lc3b_reg          src2_id;
    // execute
    lc3b_control_word cw_ex;
    lc3b_word         ir_ex;
    lc3b_word         pc2_ex;
    lc3b_word         reg_a_ex;
    lc3b_word         reg_b_ex;
    lc3b_reg          src2_ex;
    lc3b_word         opa;
    lc3b_word         opb;
    lc3b_word         alu_b;
    lc3b_word         alu_out;
    lc3b_word         br_target;
    logic             br_taken;
    // memory
    lc3b_control_word cw_mem;
    lc3b_reg          dest_mem;
    lc3b_word         alu_mem;
    lc3b_word         sdata_mem;
    lc3b_word         rdata_q;
    lc3b_word         load_data;
    logic             dmem_req;
    logic             dmem_done;
    // writeback
    lc3b_control_word cw_wb;
    lc3b_reg          dest_wb;
    lc3b_word         value_wb;
    lc3b_nzp          cc;
    lc3b_nzp          cc_new;
    logic             advance;
    logic             stall_id;
    logic             flush;

    lc3b_forward_if fwd_if ();

    function automatic lc3b_word fwd_pick(
        input lc3b_fwd_sel sel,
        input lc3b_word    reg_val,
        input lc3b_word    mem_val,
        input lc3b_word    wb_val
    );
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign pc_plus2       = pc + 16'd2;
    assign o_imem_address = pc;
    assign o_imem_read    = fetch_en;

    // fetch stage and IF/ID, a squashed or empty slot is ir zero (BR never)
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            fetch_en <= 1'b0;
            pc       <= `LC3B_RESET_PC;
            ir_id    <= '0;
        end else begin
            fetch_en <= 1'b1;
            if (advance && flush) begin
                pc    <= br_target;
                ir_id <= '0;
            end else if (advance && !stall_id) begin
                pc    <= fetch_en ? pc_plus2 : pc;
                ir_id <= fetch_en ? i_imem_rdata : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && !stall_id) begin
            pc2_id <= pc_plus2;
        end
    end

    assign o_opcode = lc3b_opcode'(ir_id[15:12]);
    assign o_ir_5   = ir_id[5];
    assign src2_id  = i_cw.src2_is_dest ? ir_id[11:9] : ir_id[2:0];

    regfile i_regfile (
        .clk,
        .i_arst_n,
        .i_load  (cw_wb.load_regfile & advance),
        .i_dest  (dest_wb),
        .i_src_a (ir_id[8:6]),
        .i_src_b (src2_id),
        .i_in    (value_wb),
        .o_reg_a (reg_a_id),
        .o_reg_b (reg_b_id)
    );

    hazard_detection i_hazard_detection (
        .i_imem_resp (i_imem_resp | ~o_imem_read),
        .i_dmem_resp (i_dmem_resp | dmem_done),
        .i_dmem_req  (dmem_req),
        .i_op_id     (o_opcode),
        .i_src1_id   (ir_id[8:6]),
        .i_src2_id   (src2_id),
        .i_dest_ex   (ir_ex[11:9]),
        .i_load_ex   (cw_ex.d_mem_read),
        .i_cc_busy   ({cw_ex.load_cc, cw_mem.load_cc, cw_wb.load_cc}),
        .i_br_taken  (br_taken),
        .o_advance   (advance),
        .o_stall_id  (stall_id),
        .o_flush     (flush)
    );

    // control words, a stall or a squash inserts a bubble into execute
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cw_ex  <= '0;
            cw_mem <= '0;
            cw_wb  <= '0;
        end else if (advance) begin
            cw_ex  <= (flush || stall_id) ? '0 : i_cw;
            cw_mem <= cw_ex;
            cw_wb  <= cw_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ir_ex     <= ir_id;
            pc2_ex    <= pc2_id;
            reg_a_ex  <= reg_a_id;
            reg_b_ex  <= reg_b_id;
            src2_ex   <= src2_id;
            dest_mem  <= ir_ex[11:9];
            alu_mem   <= alu_out;
            sdata_mem <= opb;
            dest_wb   <= dest_mem;
            value_wb  <= cw_mem.d_mem_read ? load_data : alu_mem;
        end
    end

    assign fwd_if.src1_ex          = ir_ex[8:6];
    assign fwd_if.src2_ex          = src2_ex;
    assign fwd_if.dest_mem         = dest_mem;
    assign fwd_if.dest_wb          = dest_wb;
    assign fwd_if.load_regfile_mem = cw_mem.load_regfile & ~cw_mem.d_mem_read;
    assign fwd_if.load_regfile_wb  = cw_wb.load_regfile;

    forwarding_unit i_forwarding_unit (
        .fwd (fwd_if.unit)
    );

    assign opa = fwd_pick(fwd_if.fwd_a_sel, reg_a_ex, alu_mem, value_wb);
    assign opb = fwd_pick(fwd_if.fwd_b_sel, reg_b_ex, alu_mem, value_wb);

    always_comb begin
        case (cw_ex.alumux_sel)
            alumux_imm5: alu_b = {{11{ir_ex[4]}}, ir_ex[4:0]};
            // word offset for LDR and STR
            alumux_off6: alu_b = {{9{ir_ex[5]}}, ir_ex[5:0], 1'b0};
            default:     alu_b = opb;
        endcase
        case (cw_ex.aluop)
            alu_add: alu_out = opa + alu_b;
            alu_and: alu_out = opa & alu_b;
            alu_not: alu_out = ~opa;
            default: alu_out = alu_b;
        endcase
    end

    assign br_target = pc2_ex + {{6{ir_ex[8]}}, ir_ex[8:0], 1'b0};
    assign br_taken  = cw_ex.valid && cw_ex.opcode == op_br && |(ir_ex[11:9] & cc);

    // hold the access low once answered while another stage still waits
    assign dmem_req       = cw_mem.d_mem_read | cw_mem.d_mem_write;
    assign o_dmem_read    = cw_mem.d_mem_read & ~dmem_done;
    assign o_dmem_write   = cw_mem.d_mem_write & ~dmem_done;
    assign o_dmem_address = alu_mem;
    assign o_dmem_wdata   = sdata_mem;
    assign load_data      = dmem_done ? rdata_q : i_dmem_rdata;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            dmem_done <= 1'b0;
        end else if (advance) begin
            dmem_done <= 1'b0;
        end else if (dmem_req && i_dmem_resp) begin
            dmem_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_dmem_resp) begin
            rdata_q <= i_dmem_rdata;
        end
    end

    assign cc_new = value_wb[15] ? 3'b100 : (value_wb == '0) ? 3'b010 : 3'b001;

    // cc comes out of reset as zero
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cc <= 3'b010;
        end else if (advance && cw_wb.load_cc) begin
            cc <= cc_new;
        end
    end
endmodule

//--- verilog/hazard_detection.sv
module hazard_detection (
    input  logic                     i_imem_resp,
    input  logic                     i_dmem_resp,
    input  logic                     i_dmem_req,
    input  lc3b_isa_pkg::lc3b_opcode i_op_id,
    input  lc3b_isa_pkg::lc3b_reg    i_src1_id,
    input  lc3b_isa_pkg::lc3b_reg    i_src2_id,
    input  lc3b_isa_pkg::lc3b_reg    i_dest_ex,
    input  logic                     i_load_ex,
    input  logic [2:0]               i_cc_busy,
    input  logic                     i_br_taken,
    output logic                     o_advance,
    output logic                     o_stall_id,
    output logic                     o_flush
);
    import lc3b_isa_pkg::*;

    logic uses_src1;
    logic uses_src2;
    logic load_use;
    logic br_wait;

    // any missing memory response freezes the whole pipe
    assign o_advance = i_imem_resp & (~i_dmem_req | i_dmem_resp);

    // BR reads no register, NOT and LDR only the first source
    assign uses_src1 = (i_op_id != op_br);
    assign uses_src2 = (i_op_id == op_add) || (i_op_id == op_and) || (i_op_id == op_str);

    assign load_use = i_load_ex && ((uses_src1 && i_src1_id == i_dest_ex) ||
                                    (uses_src2 && i_src2_id == i_dest_ex));

    // hold BR until every older cc writer has left the pipe
    assign br_wait = (i_op_id == op_br) && (|i_cc_busy);

    assign o_flush    = i_br_taken;
    assign o_stall_id = (load_use | br_wait) & ~i_br_taken;
endmodule

//--- verilog/forwarding_unit.sv
module forwarding_unit (
    lc3b_forward_if.unit fwd
);
    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;

    // memory stage holds the younger result so it wins over writeback
    function automatic lc3b_fwd_sel pick_source(
        input lc3b_reg src,
        input lc3b_reg dest_mem,
        input logic    load_mem,
        input lc3b_reg dest_wb,
        input logic    load_wb
    );
        if (load_mem && dest_mem == src) begin
            return fwd_mem;
        end else if (load_wb && dest_wb == src) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign fwd.fwd_a_sel = pick_source(fwd.src1_ex, fwd.dest_mem, fwd.load_regfile_mem,
                                       fwd.dest_wb, fwd.load_regfile_wb);
    assign fwd.fwd_b_sel = pick_source(fwd.src2_ex, fwd.dest_mem, fwd.load_regfile_mem,
                                       fwd.dest_wb, fwd.load_regfile_wb);
endmodule

//--- verilog/regfile.sv
`include "lc3b_params.svh"

module regfile (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  logic                   i_load,
    input  lc3b_isa_pkg::lc3b_reg  i_dest,
    input  lc3b_isa_pkg::lc3b_reg  i_src_a,
    input  lc3b_isa_pkg::lc3b_reg  i_src_b,
    input  lc3b_isa_pkg::lc3b_word i_in,
    output lc3b_isa_pkg::lc3b_word o_reg_a,
    output lc3b_isa_pkg::lc3b_word o_reg_b
);
    import lc3b_isa_pkg::*;

    lc3b_word regs [`LC3B_NUM_REGS];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_load) begin
            regs[i_dest] <= i_in;
        end
    end

    // write-through, decode sees the value written back this cycle
    assign o_reg_a = (i_load && i_dest == i_src_a) ? i_in : regs[i_src_a];
    assign o_reg_b = (i_load && i_dest == i_src_b) ? i_in : regs[i_src_b];
endmodule

//--- verilog/lc3b_control_rom.sv
module lc3b_control_rom (
    input  lc3b_isa_pkg::lc3b_opcode        i_opcode,
    input  logic                            i_ir_5,
    output lc3b_ctrl_pkg::lc3b_control_word o_cw
);
    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;

    always_comb begin
        // valid word that changes no state, covers BR and unknown opcodes
        o_cw            = '0;
        o_cw.opcode     = i_opcode;
        o_cw.aluop      = alu_pass;
        o_cw.alumux_sel = alumux_reg;
        o_cw.valid      = 1'b1;
        case (i_opcode)
            op_add: begin
                o_cw.aluop        = alu_add;
                o_cw.alumux_sel   = i_ir_5 ? alumux_imm5 : alumux_reg;
                o_cw.load_regfile = 1'b1;
                o_cw.load_cc      = 1'b1;
            end
            op_and: begin
                o_cw.aluop        = alu_and;
                o_cw.alumux_sel   = i_ir_5 ? alumux_imm5 : alumux_reg;
                o_cw.load_regfile = 1'b1;
                o_cw.load_cc      = 1'b1;
            end
            op_not: begin
                o_cw.aluop        = alu_not;
                o_cw.load_regfile = 1'b1;
                o_cw.load_cc      = 1'b1;
            end
            op_ldr: begin
                o_cw.aluop        = alu_add;
                o_cw.alumux_sel   = alumux_off6;
                o_cw.d_mem_read   = 1'b1;
                o_cw.load_regfile = 1'b1;
                o_cw.load_cc      = 1'b1;
            end
            op_str: begin
                o_cw.aluop        = alu_add;
                o_cw.alumux_sel   = alumux_off6;
                o_cw.d_mem_write  = 1'b1;
                // store data comes from SR in bits 11:9 on port b
                o_cw.src2_is_dest = 1'b1;
            end
            default: ;
        endcase
    end
endmodule

//--- verilog/lc3b_forward_if.sv
interface lc3b_forward_if;
    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;

    // register tags of the execute, memory and writeback stages
    lc3b_reg     src1_ex;
    lc3b_reg     src2_ex;
    lc3b_reg     dest_mem;
    lc3b_reg     dest_wb;
    // memory flag excludes loads, their data is not ready yet
    logic        load_regfile_mem;
    logic        load_regfile_wb;
    lc3b_fwd_sel fwd_a_sel;
    lc3b_fwd_sel fwd_b_sel;

    modport datapath (
        output src1_ex, src2_ex, dest_mem, dest_wb, load_regfile_mem, load_regfile_wb,
        input  fwd_a_sel, fwd_b_sel
    );

    modport unit (
        input  src1_ex, src2_ex, dest_mem, dest_wb, load_regfile_mem, load_regfile_wb,
        output fwd_a_sel, fwd_b_sel
    );
endinterface

//--- verilog/lc3b_ctrl_pkg.sv
package lc3b_ctrl_pkg;

    typedef enum logic [1:0] {
        alu_add  = 2'b00,
        alu_and  = 2'b01,
        alu_not  = 2'b10,
        alu_pass = 2'b11
    } lc3b_aluop;

    // second ALU operand
    typedef enum logic [1:0] {
        alumux_reg  = 2'b00,
        alumux_imm5 = 2'b01,
        alumux_off6 = 2'b10
    } lc3b_alumux_sel;

    // execute operand source
    typedef enum logic [1:0] {
        fwd_none = 2'b00,
        fwd_mem  = 2'b01,
        fwd_wb   = 2'b10
    } lc3b_fwd_sel;

    // all zero is a pipeline bubble
    typedef struct packed {
        lc3b_isa_pkg::lc3b_opcode opcode;
        lc3b_aluop                aluop;
        lc3b_alumux_sel           alumux_sel;
        logic                     load_regfile;
        logic                     load_cc;
        logic                     d_mem_read;
        logic                     d_mem_write;
        logic                     src2_is_dest;
        logic                     valid;
    } lc3b_control_word;

endpackage

//--- verilog/lc3b_isa_pkg.sv
`include "lc3b_params.svh"

package lc3b_isa_pkg;

    // data word and address
    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;

    // register index
    typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;

    // negative, zero, positive
    typedef logic [2:0] lc3b_nzp;

    // LC-3b encodings of the supported subset
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

endpackage

//--- include/lc3b_params.svh
`ifndef LC3B_PARAMS_SVH
`define LC3B_PARAMS_SVH

// data and address width in bits
`define LC3B_WORD_W 16

// general purpose registers R0 to R7
`define LC3B_NUM_REGS 8

// first fetch address after reset
`define LC3B_RESET_PC 16'h0000

`endif
